/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - hw/mem_map_pkg.sv
      - hw/mem_access_pkg.sv
      - hw/clint_timer.sv
      - hw/data_ram.sv
      - hw/io_reg_port.sv
      - hw/mem_space_router.sv
      - hw/mem_subsystem_top.sv
  - target: simulation
    files:
      - dv/mem_subsystem_checker.sv
      - dv/mem_subsystem_tb.sv

/* dv/mem_subsystem_checker.sv */
// Concurrent assertions on the memory-space handshake
// Bound to the top level, failures counted for the testbench

`timescale 1ns/10ps

module mem_subsystem_checker (
    input logic                     clk,
    input logic                     reset,
    input mem_access_pkg::mem_req_t req_i,
    input mem_access_pkg::mem_rsp_t rsp_o
);

    int unsigned fail_cnt = 0;
    logic        outstanding_q;

    // Set on acceptance, cleared by the completion strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding_q <= 1'b0;
        end else if (req_i.en) begin
            outstanding_q <= 1'b1;
        end else if (rsp_o.done) begin
            outstanding_q <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Handshake properties
    // --------------------------------------------------
    done_not_with_miss: assert property (@(posedge clk) disable iff (reset)
        !(rsp_o.done && rsp_o.miss))
        else begin
            fail_cnt++;
            $error("done and miss are high in the same cycle");
        end

    no_req_while_busy: assert property (@(posedge clk) disable iff (reset)
        req_i.en |-> !outstanding_q)
        else begin
            fail_cnt++;
            $error("new request while an access is outstanding");
        end

    // First cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !rsp_o.done && !rsp_o.miss && !rsp_o.write_hit)
        else begin
            fail_cnt++;
            $error("response flags not low after reset");
        end

endmodule

bind mem_subsystem_top mem_subsystem_checker mem_subsystem_checker_i (
    .clk   (clk),
    .reset (reset),
    .req_i (req_i),
    .rsp_o (rsp_o)
);

/* dv/mem_subsystem_tb.sv */
// Testbench for the memory-space top level
// Directed table, random phase against a reference model, compare tasks

`timescale 1ns/10ps

module mem_subsystem_tb;
    import mem_access_pkg::*;
    import mem_map_pkg::*;

    localparam int NUM_DIR    = 18;
    localparam int NUM_RAND   = 60;
    localparam int FILL_WORDS = 32;
    localparam int DONE_LIMIT = 20;
    localparam int IRQ_LIMIT  = 300;

    typedef struct packed {
        mem_target_e tgt;
        wen_t        wen;
        addr_t       addr;
        data_t       wdata;
        data_t       exp_rdata;
        logic        chk_rd;
    } dir_entry_t;

    logic        clk;
    logic        reset;
    mem_req_t    req;
    mem_rsp_t    rsp;
    logic        timer_irq;
    dir_entry_t  dir_tab [NUM_DIR];
    data_t       ram_model [FILL_WORDS];
    data_t       io_model [4];
    logic [31:0] rng_state;

    mem_subsystem_top mem_subsystem_top_i (
        .clk         (clk),
        .reset       (reset),
        .req_i       (req),
        .rsp_o       (rsp),
        .timer_irq_o (timer_irq)
    );

    always #50 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Byte mask built from the strobes
    function automatic data_t strobe_merge(data_t old_word, data_t new_word, wen_t wen);
        data_t mask;
        mask = {{8{wen[3]}}, {8{wen[2]}}, {8{wen[1]}}, {8{wen[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic report_error(string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            report_error("data mismatch");
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %b, got %b", $time, name, exp, act);
            report_error("flag mismatch");
        end
    endtask

    // One request strobe, then wait for done
    task automatic do_access(input wen_t wen, input addr_t addr, input data_t wdata,
                             output mem_rsp_t got);
        int cnt;
        @(posedge clk);
        #1;
        req.en    = 1'b1;
        req.wen   = wen;
        req.addr  = addr;
        req.wdata = wdata;
        @(posedge clk);
        #1;
        req.en = 1'b0;
        for (cnt = 0; cnt < DONE_LIMIT; cnt++) begin
            @(negedge clk);
            if (rsp.done) break;
            // Still outstanding, so the target reports a miss
            check_flag("rsp_o.miss", 1'b1, rsp.miss);
        end
        if (!rsp.done) begin
            report_error($sformatf("no done for the access to %h", addr));
        end
        got = rsp;
    endtask

    task automatic fill_table();
        dir_tab[0]  = '{TGT_RAM, 4'hF, RAM_BASE + 32'h10, 32'hDEAD_BEEF, 32'h0, 1'b0};
        dir_tab[1]  = '{TGT_RAM, 4'h0, RAM_BASE + 32'h10, 32'h0, 32'hDEAD_BEEF, 1'b1};
        dir_tab[2]  = '{TGT_RAM, 4'h5, RAM_BASE + 32'h10, 32'h1122_3344, 32'h0, 1'b0};
        dir_tab[3]  = '{TGT_RAM, 4'h0, RAM_BASE + 32'h10, 32'h0, 32'hDE22_BE44, 1'b1};
        // Last RAM word and the first address past it
        dir_tab[4]  = '{TGT_RAM, 4'hF, RAM_BASE + 32'h3FC, 32'hCAFE_F00D, 32'h0, 1'b0};
        dir_tab[5]  = '{TGT_RAM, 4'h0, RAM_BASE + 32'h3FC, 32'h0, 32'hCAFE_F00D, 1'b1};
        dir_tab[6]  = '{TGT_IO, 4'hF, RAM_BASE + RAM_BYTES, 32'h1234_5678, 32'h0, 1'b0};
        dir_tab[7]  = '{TGT_IO, 4'h0, RAM_BASE + RAM_BYTES, 32'h0, 32'h0, 1'b1};
        dir_tab[8]  = '{TGT_IO, 4'hF, IO_BASE, 32'hA5A5_0001, 32'h0, 1'b0};
        dir_tab[9]  = '{TGT_IO, 4'h3, IO_BASE + 32'h4, 32'h1234_BEEF, 32'h0, 1'b0};
        dir_tab[10] = '{TGT_IO, 4'h0, IO_BASE, 32'h0, 32'hA5A5_0001, 1'b1};
        dir_tab[11] = '{TGT_IO, 4'h0, IO_BASE + 32'h4, 32'h0, 32'h0000_BEEF, 1'b1};
        dir_tab[12] = '{TGT_IO, 4'hF, IO_BASE + 32'h10, 32'hFFFF_FFFF, 32'h0, 1'b0};
        dir_tab[13] = '{TGT_IO, 4'h0, IO_BASE + 32'h10, 32'h0, 32'h0, 1'b1};
        // CLINT block outside the two registers
        dir_tab[14] = '{TGT_IO, 4'hF, CLINT_BASE, 32'h55AA_55AA, 32'h0, 1'b0};
        dir_tab[15] = '{TGT_IO, 4'h0, CLINT_BASE, 32'h0, 32'h0, 1'b1};
        dir_tab[16] = '{TGT_CLINT, 4'hF, CLINT_BASE + MTIMECMP_OFFSET, 32'h1_0000,
                        32'h0, 1'b0};
        dir_tab[17] = '{TGT_CLINT, 4'h0, CLINT_BASE + MTIMECMP_OFFSET, 32'h0,
                        32'h1_0000, 1'b1};
    endtask

    // --------------------------------------------------
    // Test phases
    // --------------------------------------------------
    task automatic run_directed();
        mem_rsp_t got;
        for (int i = 0; i < NUM_DIR; i++) begin
            do_access(dir_tab[i].wen, dir_tab[i].addr, dir_tab[i].wdata, got);
            // Only RAM writes report a hit
            check_flag($sformatf("rsp_o.write_hit[entry %0d]", i),
                       (dir_tab[i].tgt == TGT_RAM) && (|dir_tab[i].wen), got.write_hit);
            if (dir_tab[i].chk_rd) begin
                check_data($sformatf("rsp_o.rdata[entry %0d]", i),
                           dir_tab[i].exp_rdata, got.rdata);
            end
        end
    endtask

    task automatic run_clint();
        mem_rsp_t got;
        data_t    first;
        int       cnt;
        do_access(4'h0, CLINT_BASE + MTIME_OFFSET, 32'h0, got);
        first = got.rdata;
        do_access(4'h0, CLINT_BASE + MTIME_OFFSET, 32'h0, got);
        if (got.rdata < first) begin
            report_error("mtime decreased between two reads");
        end
        do_access(4'hF, CLINT_BASE + MTIME_OFFSET, 32'h0, got);
        do_access(4'hF, CLINT_BASE + MTIMECMP_OFFSET, 32'h40, got);
        // mtime restarted from zero a few cycles ago
        check_flag("timer_irq_o", 1'b0, timer_irq);
        for (cnt = 0; cnt < IRQ_LIMIT; cnt++) begin
            if (timer_irq) break;
            @(negedge clk);
        end
        if (!timer_irq) begin
            report_error("timer_irq_o did not rise once mtime passed mtimecmp");
        end
        do_access(4'hF, CLINT_BASE + MTIMECMP_OFFSET, 32'hFFFF_FFFF, got);
        check_flag("timer_irq_o", 1'b0, timer_irq);
    endtask

    task automatic run_random();
        mem_rsp_t got;
        logic     to_ram;
        int       idx;
        addr_t    addr;
        wen_t     wen;
        data_t    wdata;
        // Known contents first so every read has a model value
        for (int w = 0; w < FILL_WORDS; w++) begin
            addr         = RAM_BASE + 32'(w * 4);
            ram_model[w] = addr ^ {addr[15:0], addr[31:16]};
            do_access(4'hF, addr, ram_model[w], got);
        end
        for (int k = 0; k < 4; k++) begin
            io_model[k] = ~(IO_BASE + 32'(k * 4));
            do_access(4'hF, IO_BASE + 32'(k * 4), io_model[k], got);
        end
        for (int n = 0; n < NUM_RAND; n++) begin
            rng_state = xorshift(rng_state);
            to_ram    = rng_state[0] | rng_state[1];
            idx       = to_ram ? int'(rng_state[6:2]) : int'(rng_state[3:2]);
            wen       = rng_state[7] ? rng_state[11:8] : 4'h0;
            addr      = (to_ram ? RAM_BASE : IO_BASE) + 32'(idx * 4);
            rng_state = xorshift(rng_state);
            wdata     = rng_state;
            do_access(wen, addr, wdata, got);
            check_flag("rsp_o.write_hit", to_ram && (|wen), got.write_hit);
            if (wen == 4'h0) begin
                check_data("rsp_o.rdata", to_ram ? ram_model[idx] : io_model[idx], got.rdata);
            end else if (to_ram) begin
                ram_model[idx] = strobe_merge(ram_model[idx], wdata, wen);
            end else begin
                io_model[idx] = strobe_merge(io_model[idx], wdata, wen);
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        req       = '0;
        rng_state = 32'h62c5;
        fill_table();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_flag("timer_irq_o", 1'b0, timer_irq);
        check_flag("rsp_o.done", 1'b0, rsp.done);
        run_directed();
        run_clint();
        run_random();
        if (mem_subsystem_top_i.mem_subsystem_checker_i.fail_cnt == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            report_error("handshake assertions failed during the run");
        end
    end

endmodule

/* hw/clint_timer.sv */
// CLINT timer with 32-bit mtime and mtimecmp registers
// Single-cycle read and write, level timer interrupt

`timescale 1ns/10ps

module clint_timer (
    input  logic                     clk,
    input  logic                     reset,
    input  mem_access_pkg::mem_req_t req_i,
    output mem_access_pkg::tgt_rsp_t rsp_o,
    output logic                     timer_irq_o
);
    import mem_access_pkg::*;
    import mem_map_pkg::*;

    data_t mtime_q;
    data_t mtimecmp_q;
    data_t rdata_q;
    logic  sel_mtime;
    logic  wr_en;

    // Router only enables us for the two register addresses
    assign sel_mtime = (req_i.addr == CLINT_BASE + MTIME_OFFSET);
    assign wr_en     = req_i.en && (|req_i.wen);

    // --------------------------------------------------
    // Timer registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
        end else begin
            // A write to mtime overrides the increment
            if (wr_en && sel_mtime) begin
                mtime_q <= merge_bytes(mtime_q, req_i.wdata, req_i.wen);
            end else begin
                mtime_q <= mtime_q + 1'b1;
            end

            if (wr_en && !sel_mtime) begin
                mtimecmp_q <= merge_bytes(mtimecmp_q, req_i.wdata, req_i.wen);
            end
        end
    end

    // Read value sampled at the request edge
    always_ff @(posedge clk) begin
        if (req_i.en) begin
            rdata_q <= sel_mtime ? mtime_q : mtimecmp_q;
        end
    end

    // --------------------------------------------------
    // Response
    // --------------------------------------------------
    // Never stalls and does not report write hits
    assign rsp_o.miss      = 1'b0;
    assign rsp_o.write_hit = 1'b0;
    assign rsp_o.rdata     = rdata_q;

    // Level stays high until mtimecmp moves past mtime
    assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

/* hw/data_ram.sv */
// Data RAM standing in for the data cache
// Byte-writable word array behind a fixed access latency

`timescale 1ns/10ps

module data_ram (
    input  logic                     clk,
    input  logic                     reset,
    input  mem_access_pkg::mem_req_t req_i,
    output mem_access_pkg::tgt_rsp_t rsp_o
);
    import mem_access_pkg::*;
    import mem_map_pkg::*;

    data_t                   mem_q [RAM_WORDS];
    slow_state_e             state_q;
    logic [1:0]              lat_cnt_q;
    logic [RAM_INDEX_WD-1:0] idx_q;
    wen_t                    wen_q;
    data_t                   wdata_q;
    data_t                   rdata_q;
    logic                    write_hit_q;
    logic                    accept;
    logic                    finish;

    assign accept = (state_q == ST_IDLE) && req_i.en;
    assign finish = (state_q == ST_BUSY) && (lat_cnt_q == '0);

    // --------------------------------------------------
    // Access FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= ST_IDLE;
            lat_cnt_q   <= '0;
            write_hit_q <= 1'b0;
        end else begin
            // write_hit is a one-cycle pulse with the completion
            write_hit_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (req_i.en) begin
                        state_q   <= ST_BUSY;
                        lat_cnt_q <= 2'(RAM_LATENCY - 1);
                    end
                end
                ST_BUSY: begin
                    if (lat_cnt_q == '0) begin
                        state_q     <= ST_IDLE;
                        write_hit_q <= |wen_q;
                    end else begin
                        lat_cnt_q <= lat_cnt_q - 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Request captured at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q   <= req_i.addr[RAM_INDEX_WD+1:2];
            wen_q   <= req_i.wen;
            wdata_q <= req_i.wdata;
        end
    end

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (finish) begin
            rdata_q <= mem_q[idx_q];
            if (|wen_q) begin
                mem_q[idx_q] <= merge_bytes(mem_q[idx_q], wdata_q, wen_q);
            end
        end
    end

    assign rsp_o.miss      = (state_q == ST_BUSY);
    assign rsp_o.write_hit = write_hit_q;
    assign rsp_o.rdata     = rdata_q;

endmodule

/* hw/io_reg_port.sv */
// IO register window with four scratch registers
// Fixed wait states, unmapped addresses read zero

`timescale 1ns/10ps

module io_reg_port (
    input  logic                     clk,
    input  logic                     reset,
    input  mem_access_pkg::mem_req_t req_i,
    output mem_access_pkg::tgt_rsp_t rsp_o
);
    import mem_access_pkg::*;
    import mem_map_pkg::*;

    data_t       regs_q [4];
    slow_state_e state_q;
    logic [1:0]  wait_cnt_q;
    logic        hit_q;
    logic [1:0]  idx_q;
    wen_t        wen_q;
    data_t       wdata_q;
    data_t       rdata_q;
    logic        accept;
    logic        finish;

    assign accept = (state_q == ST_IDLE) && req_i.en;
    assign finish = (state_q == ST_BUSY) && (wait_cnt_q == '0);

    // --------------------------------------------------
    // Wait-state FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= ST_IDLE;
            wait_cnt_q <= '0;
        end else if (accept) begin
            state_q    <= ST_BUSY;
            wait_cnt_q <= 2'(IO_LATENCY - 1);
        end else if (finish) begin
            state_q <= ST_IDLE;
        end else if (state_q == ST_BUSY) begin
            wait_cnt_q <= wait_cnt_q - 1'b1;
        end
    end

    // Upper address bits select the four-word window
    always_ff @(posedge clk) begin
        if (accept) begin
            hit_q   <= (req_i.addr[ADDR_WD-1:4] == IO_BASE[ADDR_WD-1:4]);
            idx_q   <= req_i.addr[3:2];
            wen_q   <= req_i.wen;
            wdata_q <= req_i.wdata;
        end
    end

    // --------------------------------------------------
    // Registers and read data
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs_q[i] <= '0;
            end
        end else if (finish && hit_q && (|wen_q)) begin
            regs_q[idx_q] <= merge_bytes(regs_q[idx_q], wdata_q, wen_q);
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            rdata_q <= hit_q ? regs_q[idx_q] : '0;
        end
    end

    assign rsp_o.miss      = (state_q == ST_BUSY);
    assign rsp_o.write_hit = 1'b0;
    assign rsp_o.rdata     = rdata_q;

endmodule

/* hw/mem_access_pkg.sv */
// Request and response types of the memory space
// Data widths, structs, target and state enums, byte merge helper

package mem_access_pkg;

    localparam int ADDR_WD = 32;
    localparam int DATA_WD = 32;
    localparam int WEN_WD  = 4;

    typedef logic [ADDR_WD-1:0] addr_t;
    typedef logic [DATA_WD-1:0] data_t;
    typedef logic [WEN_WD-1:0]  wen_t;

    // Single-cycle request strobe, wen all zero means read
    typedef struct packed {
        logic  en;
        wen_t  wen;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // Response of one target
    typedef struct packed {
        logic  miss;
        logic  write_hit;
        data_t rdata;
    } tgt_rsp_t;

    // Merged response seen by the requester
    typedef struct packed {
        logic  done;
        logic  miss;
        logic  write_hit;
        data_t rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        TGT_CLINT,
        TGT_RAM,
        TGT_IO
    } mem_target_e;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } slow_state_e;

    // Replace the strobed bytes of a word
    function automatic data_t merge_bytes(data_t old_word, data_t new_word, wen_t wen);
        data_t result;
        result = old_word;
        for (int i = 0; i < WEN_WD; i++) begin
            if (wen[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage

/* hw/mem_map_pkg.sv */
// Address map of the data-side memory space
// Region bases, sizes and fixed target latencies

package mem_map_pkg;

    // --------------------------------------------------
    // CLINT timer block
    // --------------------------------------------------
    localparam logic [31:0] CLINT_BASE      = 32'h0200_0000;
    localparam logic [31:0] MTIMECMP_OFFSET = 32'h0000_4000;
    localparam logic [31:0] MTIME_OFFSET    = 32'h0000_BFF8;

    // --------------------------------------------------
    // Data RAM window
    // --------------------------------------------------
    localparam logic [31:0] RAM_BASE  = 32'h8000_0000;
    localparam logic [31:0] RAM_BYTES = 32'h0000_0400;

    // 1 KiB of 32-bit words
    localparam int RAM_WORDS    = 256;
    localparam int RAM_INDEX_WD = 8;

    // --------------------------------------------------
    // IO register window
    // --------------------------------------------------
    // Four words starting here, everything else in the window reads zero
    localparam logic [31:0] IO_BASE = 32'h1000_0000;

    // --------------------------------------------------
    // Target latencies
    // --------------------------------------------------
    // Cycles with miss held high before the access completes
    localparam int RAM_LATENCY = 2;
    localparam int IO_LATENCY  = 3;

endpackage

/* hw/mem_space_router.sv */
// Memory-space router for load/store requests
// Address decode, per-target fan-out and response merge

`timescale 1ns/10ps

module mem_space_router (
    input  logic                     clk,
    input  logic                     reset,

    input  mem_access_pkg::mem_req_t req_i,
    output mem_access_pkg::mem_rsp_t rsp_o,

    output mem_access_pkg::mem_req_t clint_req_o,
    input  mem_access_pkg::tgt_rsp_t clint_rsp_i,

    output mem_access_pkg::mem_req_t ram_req_o,
    input  mem_access_pkg::tgt_rsp_t ram_rsp_i,

    output mem_access_pkg::mem_req_t io_req_o,
    input  mem_access_pkg::tgt_rsp_t io_rsp_i
);
    import mem_access_pkg::*;
    import mem_map_pkg::*;

    mem_target_e tgt_sel;
    mem_target_e tgt_q;
    logic        busy_q;
    tgt_rsp_t    act_rsp;
    logic        done;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    always_comb begin
        if ((req_i.addr == CLINT_BASE + MTIME_OFFSET) ||
            (req_i.addr == CLINT_BASE + MTIMECMP_OFFSET)) begin
            tgt_sel = TGT_CLINT;
        end else if ((req_i.addr >= RAM_BASE) && (req_i.addr < RAM_BASE + RAM_BYTES)) begin
            tgt_sel = TGT_RAM;
        end else begin
            // Anything unclaimed falls through to the IO window
            tgt_sel = TGT_IO;
        end
    end

    // Shared fields go everywhere, en only to the selected target
    always_comb begin
        clint_req_o    = req_i;
        ram_req_o      = req_i;
        io_req_o       = req_i;
        clint_req_o.en = req_i.en && (tgt_sel == TGT_CLINT);
        ram_req_o.en   = req_i.en && (tgt_sel == TGT_RAM);
        io_req_o.en    = req_i.en && (tgt_sel == TGT_IO);
    end

    // --------------------------------------------------
    // Outstanding access
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            tgt_q  <= TGT_CLINT;
        end else if (req_i.en) begin
            busy_q <= 1'b1;
            tgt_q  <= tgt_sel;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Response merge
    // --------------------------------------------------
    always_comb begin
        case (tgt_q)
            TGT_RAM: act_rsp = ram_rsp_i;
            TGT_IO:  act_rsp = io_rsp_i;
            default: act_rsp = clint_rsp_i;
        endcase
    end

    // Same completion rule for every target: first cycle without miss
    assign done = busy_q && !act_rsp.miss;

    assign rsp_o.done      = done;
    assign rsp_o.miss      = busy_q && act_rsp.miss;
    assign rsp_o.write_hit = busy_q && act_rsp.write_hit;
    assign rsp_o.rdata     = busy_q ? act_rsp.rdata : '0;

endmodule

/* hw/mem_subsystem_top.sv */
// Top level of the data-side memory space
// Router with CLINT, data RAM and IO port targets

`timescale 1ns/10ps

module mem_subsystem_top (
    input  logic                     clk,
    input  logic                     reset,
    input  mem_access_pkg::mem_req_t req_i,
    output mem_access_pkg::mem_rsp_t rsp_o,
    output logic                     timer_irq_o
);

    mem_access_pkg::mem_req_t clint_req;
    mem_access_pkg::mem_req_t ram_req;
    mem_access_pkg::mem_req_t io_req;
    mem_access_pkg::tgt_rsp_t clint_rsp;
    mem_access_pkg::tgt_rsp_t ram_rsp;
    mem_access_pkg::tgt_rsp_t io_rsp;

    mem_space_router mem_space_router_i (
        .clk         (clk),
        .reset       (reset),
        .req_i       (req_i),
        .rsp_o       (rsp_o),
        .clint_req_o (clint_req),
        .clint_rsp_i (clint_rsp),
        .ram_req_o   (ram_req),
        .ram_rsp_i   (ram_rsp),
        .io_req_o    (io_req),
        .io_rsp_i    (io_rsp)
    );

    // Single-cycle target
    clint_timer clint_timer_i (
        .clk         (clk),
        .reset       (reset),
        .req_i       (clint_req),
        .rsp_o       (clint_rsp),
        .timer_irq_o (timer_irq_o)
    );

    // Slow targets
    data_ram data_ram_i (
        .clk   (clk),
        .reset (reset),
        .req_i (ram_req),
        .rsp_o (ram_rsp)
    );

    io_reg_port io_reg_port_i (
        .clk   (clk),
        .reset (reset),
        .req_i (io_req),
        .rsp_o (io_rsp)
    );

endmodule

/* project.f */
hw/mem_map_pkg.sv
hw/mem_access_pkg.sv
hw/clint_timer.sv
hw/data_ram.sv
hw/io_reg_port.sv
hw/mem_space_router.sv
hw/mem_subsystem_top.sv
dv/mem_subsystem_checker.sv
dv/mem_subsystem_tb.sv
